// File: hw/core_cfg.svh
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// core sizing
`define CORE_DATA_W     16  // datapath and register width
`define CORE_NREGS      8   // architectural registers r0..r7
`define CORE_DMEM_DEPTH 16  // data memory words, low alu bits form the address

`endif

// File: hw/core_top.sv
`timescale 1ns/1ps
`default_nettype none

module core_top (
  input  logic              clk,
  input  logic              rst_n_i,
  input  logic              instr_valid_i,
  input  isa_pkg::word_t    instr_i,
  output logic              instr_ready_o,
  output logic              wb_valid_o,
  output isa_pkg::reg_idx_t wb_reg_o,
  output isa_pkg::word_t    wb_data_o,
  output logic              halt_o
);
  import isa_pkg::*;
  import pipe_pkg::*;

  // decode stage
  word_t    id_instr, id_imm, rf_data_one, rf_data_two;
  reg_idx_t id_rd, id_rs, id_rt, id_wsel;
  logic     id_use_rs, id_use_rt, id_alu_src, id_reg_write;
  logic     id_mem_read, id_mem_write, id_halt;
  alu_op_e  id_alu_op;
  res_src_e id_res_src;
  logic     stall_decode;

  // id/ex outputs
  word_t    ex_imm, ex_data_one, ex_data_two;
  reg_idx_t ex_wsel;
  logic     ex_alu_src, ex_reg_write, ex_mem_read, ex_mem_write, ex_halt;
  alu_op_e  ex_alu_op;
  res_src_e ex_res_src;

  // ex/mem outputs
  word_t    mem_alu_res, mem_store_data;
  reg_idx_t mem_wsel;
  logic     mem_reg_write, mem_mem_read, mem_mem_write, mem_halt;
  res_src_e mem_res_src;

  decode_unit u_decode (
    .clk(clk), .rst_n_i(rst_n_i), .instr_valid_i(instr_valid_i), .instr_i(instr_i),
    .stall_i(stall_decode), .instr_o(id_instr), .rd_o(id_rd), .rs_o(id_rs), .rt_o(id_rt),
    .write_sel_o(id_wsel), .use_rs_o(id_use_rs), .use_rt_o(id_use_rt),
    .alu_op_o(id_alu_op), .alu_src_o(id_alu_src), .reg_write_o(id_reg_write),
    .mem_read_o(id_mem_read), .mem_write_o(id_mem_write), .res_src_o(id_res_src),
    .halt_o(id_halt), .immediate_o(id_imm)
  );

  reg_file u_reg_file (
    .clk(clk), .rst_n_i(rst_n_i), .rs_i(id_rs), .rt_i(id_rt),
    .we_i(wb_valid_o), .wr_idx_i(wb_reg_o), .wr_data_i(wb_data_o),  // from mem/wb
    .data_one_o(rf_data_one), .data_two_o(rf_data_two)
  );

  hazard_unit u_hazard (
    .clk(clk), .rst_n_i(rst_n_i), .instr_valid_i(instr_valid_i),
    .rs_i(id_rs), .rt_i(id_rt), .use_rs_i(id_use_rs), .use_rt_i(id_use_rt),
    .ex_dst_i(ex_wsel), .ex_wr_i(ex_reg_write), .mem_dst_i(mem_wsel),
    .mem_wr_i(mem_reg_write), .halt_seen_i(id_halt),
    .stall_o(stall_decode), .instr_ready_o(instr_ready_o)
  );

  // instr and source fields are carried but not used past id/ex
  pipe_id_ex u_id_ex (
    .clk(clk), .rst_n_i(rst_n_i), .stall_decode_i(stall_decode),
    .instr_i(id_instr), .rd_i(id_rd), .rs_i(id_rs), .rt_i(id_rt), .write_sel_i(id_wsel),
    .use_rs_i(id_use_rs), .use_rt_i(id_use_rt), .alu_op_i(id_alu_op),
    .alu_src_i(id_alu_src), .reg_write_i(id_reg_write), .mem_read_i(id_mem_read),
    .mem_write_i(id_mem_write), .res_src_i(id_res_src), .halt_i(id_halt),
    .immediate_i(id_imm), .data_one_i(rf_data_one), .data_two_i(rf_data_two),
    .instr_o(), .rd_o(), .rs_o(), .rt_o(), .write_sel_o(ex_wsel),
    .use_rs_o(), .use_rt_o(), .alu_op_o(ex_alu_op), .alu_src_o(ex_alu_src),
    .reg_write_o(ex_reg_write), .mem_read_o(ex_mem_read), .mem_write_o(ex_mem_write),
    .res_src_o(ex_res_src), .halt_o(ex_halt), .immediate_o(ex_imm),
    .data_one_o(ex_data_one), .data_two_o(ex_data_two)
  );

  exec_unit u_exec (
    .clk(clk), .rst_n_i(rst_n_i), .alu_op_i(ex_alu_op), .alu_src_i(ex_alu_src),
    .reg_write_i(ex_reg_write), .mem_read_i(ex_mem_read), .mem_write_i(ex_mem_write),
    .res_src_i(ex_res_src), .halt_i(ex_halt), .write_sel_i(ex_wsel),
    .immediate_i(ex_imm), .data_one_i(ex_data_one), .data_two_i(ex_data_two),
    .alu_res_o(mem_alu_res), .store_data_o(mem_store_data), .write_sel_o(mem_wsel),
    .reg_write_o(mem_reg_write), .mem_read_o(mem_mem_read), .mem_write_o(mem_mem_write),
    .res_src_o(mem_res_src), .halt_o(mem_halt)
  );

  mem_wb_stage u_mem_wb (
    .clk(clk), .rst_n_i(rst_n_i), .alu_res_i(mem_alu_res), .store_data_i(mem_store_data),
    .write_sel_i(mem_wsel), .reg_write_i(mem_reg_write), .mem_read_i(mem_mem_read),
    .mem_write_i(mem_mem_write), .res_src_i(mem_res_src), .halt_i(mem_halt),
    .wb_valid_o(wb_valid_o), .wb_reg_o(wb_reg_o), .wb_data_o(wb_data_o), .halt_o(halt_o)
  );

endmodule

`default_nettype wire

// File: hw/decode_unit.sv
`timescale 1ns/1ps
`default_nettype none

module decode_unit (
  input  logic               clk,
  input  logic               rst_n_i,
  input  logic               instr_valid_i,
  input  isa_pkg::word_t     instr_i,
  input  logic               stall_i,       // raw hazard, hold if/id
  output isa_pkg::word_t     instr_o,
  output isa_pkg::reg_idx_t  rd_o,
  output isa_pkg::reg_idx_t  rs_o,
  output isa_pkg::reg_idx_t  rt_o,          // second read port index
  output isa_pkg::reg_idx_t  write_sel_o,
  output logic               use_rs_o,
  output logic               use_rt_o,
  output pipe_pkg::alu_op_e  alu_op_o,
  output logic               alu_src_o,     // 1 = immediate is operand b
  output logic               reg_write_o,
  output logic               mem_read_o,
  output logic               mem_write_o,
  output pipe_pkg::res_src_e res_src_o,
  output logic               halt_o,
  output isa_pkg::word_t     immediate_o
);
  import isa_pkg::*;
  import pipe_pkg::*;

  word_t   if_id_q;   // if/id register
  logic    closed_q;  // feed shut for good once halt decoded
  logic    take;      // feed beat lands in if/id this edge
  opcode_e opc;

  // same condition as instr_ready_o, seen from the decode side
  assign take = instr_valid_i && !stall_i && !halt_o && !closed_q;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      if_id_q  <= NOP_INSTR;
      closed_q <= 1'b0;
    end else begin
      if (halt_o) begin
        closed_q <= 1'b1;
      end
      if (!stall_i) begin
        if_id_q <= take ? instr_i : NOP_INSTR;  // empty slot becomes nop
      end
    end
  end

  ////////////////////////////////////////
  // fields and immediate
  assign opc         = opcode_e'(if_id_q[OPC_LSB +: $bits(opcode_e)]);
  assign instr_o     = if_id_q;
  assign rd_o        = if_id_q[RD_LSB +: $bits(reg_idx_t)];
  assign rs_o        = if_id_q[RS_LSB +: $bits(reg_idx_t)];
  assign rt_o        = (opc == ST) ? rd_o : if_id_q[RT_LSB +: $bits(reg_idx_t)];  // st data
  assign write_sel_o = rd_o;
  assign immediate_o = (opc == LDI) ? word_t'(if_id_q[IMM9_W-1:0])          // zero ext
                                    : word_t'(signed'(if_id_q[IMM6_W-1:0])); // sign ext

  ////////////////////////////////////////
  // control decode
  always_comb begin
    use_rs_o    = 1'b0;
    use_rt_o    = 1'b0;
    alu_src_o   = 1'b0;
    reg_write_o = 1'b0;
    mem_read_o  = 1'b0;
    mem_write_o = 1'b0;
    res_src_o   = RES_ALU;
    halt_o      = 1'b0;
    case (opc)
      ADD, SUB, AND, OR, XOR, SLL: begin  // rd = rs op rt
        use_rs_o    = 1'b1;
        use_rt_o    = 1'b1;
        reg_write_o = 1'b1;
      end
      ADDI: begin
        use_rs_o    = 1'b1;
        alu_src_o   = 1'b1;
        reg_write_o = 1'b1;
      end
      LDI: begin
        alu_src_o   = 1'b1;
        reg_write_o = 1'b1;
      end
      LD: begin
        use_rs_o    = 1'b1;   // base
        alu_src_o   = 1'b1;
        reg_write_o = 1'b1;
        mem_read_o  = 1'b1;
        res_src_o   = RES_MEM;
      end
      ST: begin
        use_rs_o    = 1'b1;
        use_rt_o    = 1'b1;   // rd value rides on port two
        alu_src_o   = 1'b1;
        mem_write_o = 1'b1;
      end
      HALT:    halt_o = 1'b1;
      default: ;              // nop and spare codes do nothing
    endcase
  end

  always_comb begin
    case (opc)
      SUB:     alu_op_o = ALU_SUB;
      AND:     alu_op_o = ALU_AND;
      OR:      alu_op_o = ALU_OR;
      XOR:     alu_op_o = ALU_XOR;
      SLL:     alu_op_o = ALU_SLL;
      LDI:     alu_op_o = ALU_PASSB;
      default: alu_op_o = ALU_ADD;  // add, addi, ld, st
    endcase
  end

endmodule

`default_nettype wire

// File: hw/exec_unit.sv
`timescale 1ns/1ps
`default_nettype none

module exec_unit (
  input  logic               clk,
  input  logic               rst_n_i,
  input  pipe_pkg::alu_op_e  alu_op_i,
  input  logic               alu_src_i,
  input  logic               reg_write_i,
  input  logic               mem_read_i,
  input  logic               mem_write_i,
  input  pipe_pkg::res_src_e res_src_i,
  input  logic               halt_i,
  input  isa_pkg::reg_idx_t  write_sel_i,
  input  isa_pkg::word_t     immediate_i,
  input  isa_pkg::word_t     data_one_i,
  input  isa_pkg::word_t     data_two_i,
  output isa_pkg::word_t     alu_res_o,     // result or memory address
  output isa_pkg::word_t     store_data_o,
  output isa_pkg::reg_idx_t  write_sel_o,   // also to hazard_unit
  output logic               reg_write_o,
  output logic               mem_read_o,
  output logic               mem_write_o,
  output pipe_pkg::res_src_e res_src_o,
  output logic               halt_o
);
  import isa_pkg::*;
  import pipe_pkg::*;

  word_t op_b;
  word_t alu_d;

  assign op_b = alu_src_i ? immediate_i : data_two_i;

  always_comb begin
    case (alu_op_i)
      ALU_ADD:   alu_d = data_one_i + op_b;  // wraps at 16 bits
      ALU_SUB:   alu_d = data_one_i - op_b;
      ALU_AND:   alu_d = data_one_i & op_b;
      ALU_OR:    alu_d = data_one_i | op_b;
      ALU_XOR:   alu_d = data_one_i ^ op_b;
      ALU_SLL:   alu_d = data_one_i << op_b[3:0];
      default:   alu_d = op_b;               // passb
    endcase
  end

  ////////////////////////////////////////
  // ex/mem register
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      reg_write_o <= 1'b0;
      mem_read_o  <= 1'b0;
      mem_write_o <= 1'b0;
      halt_o      <= 1'b0;
    end else begin
      reg_write_o <= reg_write_i;
      mem_read_o  <= mem_read_i;
      mem_write_o <= mem_write_i;
      halt_o      <= halt_i;
    end
  end

  always_ff @(posedge clk) begin
    alu_res_o    <= alu_d;
    store_data_o <= data_two_i;
    write_sel_o  <= write_sel_i;
    res_src_o    <= res_src_i;
  end

endmodule

`default_nettype wire

// File: hw/hazard_unit.sv
`timescale 1ns/1ps
`default_nettype none

module hazard_unit (
  input  logic              clk,
  input  logic              rst_n_i,
  input  logic              instr_valid_i,
  input  isa_pkg::reg_idx_t rs_i,
  input  isa_pkg::reg_idx_t rt_i,
  input  logic              use_rs_i,
  input  logic              use_rt_i,
  input  isa_pkg::reg_idx_t ex_dst_i,     // id/ex destination
  input  logic              ex_wr_i,
  input  isa_pkg::reg_idx_t mem_dst_i,    // ex/mem destination
  input  logic              mem_wr_i,
  input  logic              halt_seen_i,  // if/id holds halt
  output logic              stall_o,
  output logic              instr_ready_o
);
  logic halted_q;
  logic rs_hit;
  logic rt_hit;

  // mem/wb left out, reg_file forwards its own write
  assign rs_hit = use_rs_i && ((ex_wr_i && rs_i == ex_dst_i) || (mem_wr_i && rs_i == mem_dst_i));
  assign rt_hit = use_rt_i && ((ex_wr_i && rt_i == ex_dst_i) || (mem_wr_i && rt_i == mem_dst_i));

  assign stall_o       = rs_hit || rt_hit;
  assign instr_ready_o = !stall_o && !halted_q && !halt_seen_i;  // nothing after halt

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      halted_q <= 1'b0;
    end else if (halt_seen_i) begin
      halted_q <= 1'b1;  // sticky until reset
    end
  end

  // from the cycle after halt is decoded the feed never takes a beat
  ap_feed_closed: assert property (@(posedge clk) disable iff (!rst_n_i)
    (halt_seen_i || halted_q) |=> !(instr_valid_i && instr_ready_o));

endmodule

`default_nettype wire

// File: hw/isa_pkg.sv
`default_nettype none

`include "core_cfg.svh"

package isa_pkg;

  typedef logic [`CORE_DATA_W-1:0]        word_t;     // register / memory word
  typedef logic [$clog2(`CORE_NREGS)-1:0] reg_idx_t;  // register number

  // top nibble of every instruction
  typedef enum logic [3:0] {
    NOP  = 4'h0,
    ADD  = 4'h1,
    SUB  = 4'h2,
    AND  = 4'h3,
    OR   = 4'h4,
    XOR  = 4'h5,
    SLL  = 4'h6,  // shift by low four bits of rt value
    ADDI = 4'h7,
    LDI  = 4'h8,
    LD   = 4'h9,
    ST   = 4'ha,  // rd field names the stored register
    HALT = 4'hb
  } opcode_e;

  ////////////////////////////////////////
  // field positions
  localparam int unsigned OPC_LSB = 12;
  localparam int unsigned RD_LSB  = 9;
  localparam int unsigned RS_LSB  = 6;
  localparam int unsigned RT_LSB  = 3;
  localparam int unsigned IMM6_W  = 6;  // addi / ld / st offset, signed
  localparam int unsigned IMM9_W  = 9;  // ldi constant, zero extended

  localparam word_t NOP_INSTR = '0;  // opcode NOP, all fields zero

endpackage

`default_nettype wire

// File: hw/mem_wb_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_cfg.svh"

module mem_wb_stage (
  input  logic               clk,
  input  logic               rst_n_i,
  input  isa_pkg::word_t     alu_res_i,
  input  isa_pkg::word_t     store_data_i,
  input  isa_pkg::reg_idx_t  write_sel_i,
  input  logic               reg_write_i,
  input  logic               mem_read_i,
  input  logic               mem_write_i,
  input  pipe_pkg::res_src_e res_src_i,
  input  logic               halt_i,
  output logic               wb_valid_o,  // also the reg_file write enable
  output isa_pkg::reg_idx_t  wb_reg_o,
  output isa_pkg::word_t     wb_data_o,
  output logic               halt_o       // sticky
);
  import isa_pkg::*;
  import pipe_pkg::*;

  localparam int unsigned AW = $clog2(`CORE_DMEM_DEPTH);

  word_t          mem_q [`CORE_DMEM_DEPTH];
  logic [AW-1:0]  addr;
  word_t          load_data;

  assign addr      = alu_res_i[AW-1:0];  // upper address bits ignored
  assign load_data = mem_read_i ? mem_q[addr] : '0;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      mem_q <= '{default: '0};  // unwritten words read zero
    end else if (mem_write_i) begin
      mem_q[addr] <= store_data_i;
    end
  end

  ////////////////////////////////////////
  // mem/wb register
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      wb_valid_o <= 1'b0;
      halt_o     <= 1'b0;
    end else begin
      wb_valid_o <= reg_write_i;
      if (halt_i) begin
        halt_o <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    wb_reg_o  <= write_sel_i;
    wb_data_o <= (res_src_i == RES_MEM) ? load_data : alu_res_i;
  end

  // decode never sets both for one instruction
  ap_rw_excl: assert property (@(posedge clk) disable iff (!rst_n_i)
    !(mem_read_i && mem_write_i));

endmodule

`default_nettype wire

// File: hw/pipe_id_ex.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_id_ex (
  input  logic               clk,
  input  logic               rst_n_i,
  input  logic               stall_decode_i,  // slot becomes a bubble
  input  isa_pkg::word_t     instr_i,
  input  isa_pkg::reg_idx_t  rd_i,
  input  isa_pkg::reg_idx_t  rs_i,
  input  isa_pkg::reg_idx_t  rt_i,
  input  isa_pkg::reg_idx_t  write_sel_i,
  input  logic               use_rs_i,
  input  logic               use_rt_i,
  input  pipe_pkg::alu_op_e  alu_op_i,
  input  logic               alu_src_i,
  input  logic               reg_write_i,
  input  logic               mem_read_i,
  input  logic               mem_write_i,
  input  pipe_pkg::res_src_e res_src_i,
  input  logic               halt_i,
  input  isa_pkg::word_t     immediate_i,
  input  isa_pkg::word_t     data_one_i,
  input  isa_pkg::word_t     data_two_i,
  output isa_pkg::word_t     instr_o,
  output isa_pkg::reg_idx_t  rd_o,
  output isa_pkg::reg_idx_t  rs_o,
  output isa_pkg::reg_idx_t  rt_o,
  output isa_pkg::reg_idx_t  write_sel_o,
  output logic               use_rs_o,
  output logic               use_rt_o,
  output pipe_pkg::alu_op_e  alu_op_o,
  output logic               alu_src_o,
  output logic               reg_write_o,
  output logic               mem_read_o,
  output logic               mem_write_o,
  output pipe_pkg::res_src_e res_src_o,
  output logic               halt_o,
  output isa_pkg::word_t     immediate_o,
  output isa_pkg::word_t     data_one_o,
  output isa_pkg::word_t     data_two_o
);
  import isa_pkg::*;

  ////////////////////////////////////////
  // enables, cleared for a bubble
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      instr_o     <= NOP_INSTR;
      reg_write_o <= 1'b0;
      mem_read_o  <= 1'b0;
      mem_write_o <= 1'b0;
      halt_o      <= 1'b0;
    end else begin
      instr_o     <= stall_decode_i ? NOP_INSTR : instr_i;
      reg_write_o <= reg_write_i && !stall_decode_i;
      mem_read_o  <= mem_read_i && !stall_decode_i;
      mem_write_o <= mem_write_i && !stall_decode_i;
      halt_o      <= halt_i && !stall_decode_i;
    end
  end

  // payload, don't care while the enables are low
  always_ff @(posedge clk) begin
    rd_o        <= rd_i;
    rs_o        <= rs_i;
    rt_o        <= rt_i;
    write_sel_o <= write_sel_i;
    use_rs_o    <= use_rs_i;
    use_rt_o    <= use_rt_i;
    alu_op_o    <= alu_op_i;
    alu_src_o   <= alu_src_i;
    res_src_o   <= res_src_i;
    immediate_o <= immediate_i;
    data_one_o  <= data_one_i;  // rs value
    data_two_o  <= data_two_i;  // rt value or st data
  end

  // a stalled decode slot never reaches ex as a write
  ap_bubble: assert property (@(posedge clk) disable iff (!rst_n_i)
    stall_decode_i |=> !reg_write_o && !mem_write_o);

endmodule

`default_nettype wire

// File: hw/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

  // alu function, picked in decode
  typedef enum logic [2:0] {
    ALU_ADD   = 3'd0,  // also forms ld/st addresses
    ALU_SUB   = 3'd1,
    ALU_AND   = 3'd2,
    ALU_OR    = 3'd3,
    ALU_XOR   = 3'd4,
    ALU_SLL   = 3'd5,
    ALU_PASSB = 3'd6   // operand b straight through, used by ldi
  } alu_op_e;

  // writeback value source
  typedef enum logic {
    RES_ALU = 1'b0,
    RES_MEM = 1'b1
  } res_src_e;

endpackage

`default_nettype wire

// File: hw/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_cfg.svh"

module reg_file (
  input  logic              clk,
  input  logic              rst_n_i,
  input  isa_pkg::reg_idx_t rs_i,
  input  isa_pkg::reg_idx_t rt_i,
  input  logic              we_i,       // writeback beat
  input  isa_pkg::reg_idx_t wr_idx_i,
  input  isa_pkg::word_t    wr_data_i,
  output isa_pkg::word_t    data_one_o,  // rs value
  output isa_pkg::word_t    data_two_o   // rt value, rd for st
);
  import isa_pkg::*;

  word_t regs_q [`CORE_NREGS];

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      regs_q <= '{default: '0};
    end else if (we_i) begin
      regs_q[wr_idx_i] <= wr_data_i;
    end
  end

  // write-through, so a value in mem/wb needs no stall
  assign data_one_o = (we_i && wr_idx_i == rs_i) ? wr_data_i : regs_q[rs_i];
  assign data_two_o = (we_i && wr_idx_i == rt_i) ? wr_data_i : regs_q[rt_i];

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# build core_tb with verilator and run it, exit status follows the simulation
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module core_tb \
  -Mdir obj_dir -o core_tb_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/core_tb_sim
status=$?
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit $status
fi

exit 0

// File: tests/core_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_cfg.svh"

module core_tb;
  import isa_pkg::*;

  localparam int unsigned RND_SEED = 45;
  localparam int unsigned N_RANDOM = 150;  // random body between prefix and halt
  localparam int unsigned EXP_W    = $bits(reg_idx_t) + $bits(word_t);

  logic     clk = 1'b0;
  logic     rst_n_i;
  logic     instr_valid_i;
  word_t    instr_i;
  logic     instr_ready_o;
  logic     wb_valid_o;
  reg_idx_t wb_reg_o;
  word_t    wb_data_o;
  logic     halt_o;

  word_t            prog [$];       // program in feed order, halt last
  logic [EXP_W-1:0] exp_q [$];      // {reg, value} per expected writeback
  word_t            model_regs [`CORE_NREGS];
  word_t            model_mem [`CORE_DMEM_DEPTH];
  logic             exp_avail;      // queue front, changed on falling edges only
  reg_idx_t         exp_reg;
  word_t            exp_data;
  logic             raw_chk;        // beat taken last edge reads the one taken just before
  int unsigned      cycle_limit;
  int unsigned      cycle_count = 0;
  int unsigned      raw_hits;

  core_top dut_i (
    .clk(clk), .rst_n_i(rst_n_i), .instr_valid_i(instr_valid_i), .instr_i(instr_i),
    .instr_ready_o(instr_ready_o), .wb_valid_o(wb_valid_o), .wb_reg_o(wb_reg_o),
    .wb_data_o(wb_data_o), .halt_o(halt_o)
  );

  always #5 clk = ~clk;  // 10 ns period

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("SOME TESTS FAILED");
    $fatal(1);
  endtask

  ////////////////////////////////////////
  // instruction encoding
  function automatic word_t rtype_word(opcode_e op, reg_idx_t rd, reg_idx_t rs, reg_idx_t rt);
    return {op, rd, rs, rt, 3'b000};
  endfunction

  function automatic word_t imm_word(opcode_e op, reg_idx_t rd, reg_idx_t rs, logic [5:0] imm);
    return {op, rd, rs, imm};  // addi / ld / st, signed offset
  endfunction

  function automatic word_t ldi_word(reg_idx_t rd, logic [8:0] imm);
    return {LDI, rd, imm};
  endfunction

  // instructions that update their rd register
  function automatic logic writes_reg(word_t ins);
    case (opcode_e'(ins[15:12]))
      ADD, SUB, AND, OR, XOR, SLL, ADDI, LDI, LD: return 1'b1;
      default:                                    return 1'b0;
    endcase
  endfunction

  // true when ins reads register r
  function automatic logic reads_reg(word_t ins, reg_idx_t r);
    case (opcode_e'(ins[15:12]))
      ADD, SUB, AND, OR, XOR, SLL: return ins[8:6] == r || ins[5:3] == r;
      ADDI, LD:                    return ins[8:6] == r;
      ST:                          return ins[8:6] == r || ins[11:9] == r;  // rd is the data
      default:                     return 1'b0;
    endcase
  endfunction

  // reference model, one instruction per accepted beat
  task automatic run_model(input word_t ins);
    reg_idx_t   rd;
    word_t      a;
    word_t      b;
    word_t      imm6;
    word_t      sum;
    word_t      res;
    logic       wr;
    logic [3:0] addr;
    rd   = ins[11:9];
    a    = model_regs[ins[8:6]];
    b    = model_regs[ins[5:3]];
    imm6 = {{10{ins[5]}}, ins[5:0]};
    sum  = a + imm6;
    addr = sum[3:0];  // memory wraps on the low four bits
    res  = '0;
    wr   = 1'b1;
    case (opcode_e'(ins[15:12]))
      ADD:  res = a + b;
      SUB:  res = a - b;
      AND:  res = a & b;
      OR:   res = a | b;
      XOR:  res = a ^ b;
      SLL:  res = a << b[3:0];
      ADDI: res = sum;
      LDI:  res = {7'b0, ins[8:0]};
      LD:   res = model_mem[addr];
      ST: begin
        model_mem[addr] = model_regs[rd];  // rd names the data
        wr = 1'b0;
      end
      default: wr = 1'b0;  // nop, halt
    endcase
    if (wr) begin
      model_regs[rd] = res;
      exp_q.push_back({rd, res});
    end
  endtask

  task automatic make_program();
    opcode_e  op;
    reg_idx_t rd;
    reg_idx_t rs;
    reg_idx_t rt;
    // directed prefix, memory still all zero here
    prog.push_back(ldi_word(3'd1, 9'h1a5));
    prog.push_back(imm_word(ST, 3'd1, 3'd0, 6'd3));     // stalls on r1
    prog.push_back(imm_word(LD, 3'd2, 3'd0, 6'd3));     // reads the stored word back
    prog.push_back(imm_word(LD, 3'd3, 3'd0, 6'd9));     // never written
    prog.push_back(rtype_word(ADD, 3'd4, 3'd2, 3'd2));  // load-use
    prog.push_back(rtype_word(SUB, 3'd5, 3'd0, 3'd4));  // wraps below zero
    prog.push_back(ldi_word(3'd6, 9'h00f));
    prog.push_back(rtype_word(SLL, 3'd7, 3'd1, 3'd6));  // shift by 15
    prog.push_back(imm_word(ADDI, 3'd1, 3'd1, 6'h20));  // -32
    prog.push_back(rtype_word(NOP, 3'd0, 3'd0, 3'd0));
    for (int i = 0; i < N_RANDOM; i++) begin
      op = opcode_e'(4'($urandom_range(10)));  // nop .. st, never halt
      rd = reg_idx_t'($urandom_range(5));      // few registers, many hazards
      rs = reg_idx_t'($urandom_range(5));
      rt = reg_idx_t'($urandom_range(5));
      case (op)
        LDI:          prog.push_back(ldi_word(rd, 9'($urandom)));
        ADDI, LD, ST: prog.push_back(imm_word(op, rd, rs, 6'($urandom)));
        default:      prog.push_back(rtype_word(op, rd, rs, rt));
      endcase
    end
    prog.push_back(rtype_word(HALT, 3'd0, 3'd0, 3'd0));
  endtask

  ////////////////////////////////////////
  // writeback and halt checks
  a_wb_expected: assert property (@(posedge clk) disable iff (!rst_n_i)
    wb_valid_o |-> exp_avail)
    else fail_run($sformatf("writeback to r%0d at %0t with no instruction left to retire",
                            $sampled(wb_reg_o), $time));

  a_wb_reg: assert property (@(posedge clk) disable iff (!rst_n_i)
    (wb_valid_o && exp_avail) |-> wb_reg_o == exp_reg)
    else fail_run($sformatf("[ERROR] %0t wb_reg_o: got %0d, expected %0d",
                            $time, $sampled(wb_reg_o), exp_reg));

  a_wb_data: assert property (@(posedge clk) disable iff (!rst_n_i)
    (wb_valid_o && exp_avail) |-> wb_data_o == exp_data)
    else fail_run($sformatf("[ERROR] %0t wb_data_o: got 0x%h, expected 0x%h",
                            $time, $sampled(wb_data_o), exp_data));

  // producer sits in id/ex while its consumer waits in if/id
  a_raw_stall: assert property (@(posedge clk) disable iff (!rst_n_i)
    raw_chk |-> !instr_ready_o)
    else fail_run($sformatf("[ERROR] %0t instr_ready_o: got 1, expected 0 behind a producer",
                            $time));

  a_halt_sticky: assert property (@(posedge clk) disable iff (!rst_n_i)
    halt_o |=> halt_o)
    else fail_run($sformatf("halt_o dropped after rising, at %0t", $time));

  a_halt_ready: assert property (@(posedge clk) disable iff (!rst_n_i)
    halt_o |-> !instr_ready_o)
    else fail_run($sformatf("[ERROR] %0t instr_ready_o: got 1, expected 0 after halt",
                            $time));

  // hung run guard
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > cycle_limit) begin
      fail_run($sformatf("timeout, halt not reached within %0d cycles", cycle_limit));
    end
  end

  ////////////////////////////////////////
  // feed driver, model and queue upkeep
  initial begin
    int unsigned pc;
    bit          pending;      // offered beat not yet taken
    bit          accepted;
    bit          seen_beat;    // writeback shown, checked at the next rising edge
    bit          halt_taken;
    int unsigned halt_cycles;
    bit          raw_next;     // beat going in now depends on the previous edge's beat
    bit          prev_wr;      // beat taken at the previous edge writes prev_dst
    reg_idx_t    prev_dst;
    void'($urandom(RND_SEED));
    rst_n_i       = 1'b0;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    exp_avail     = 1'b0;
    exp_reg       = '0;
    exp_data      = '0;
    raw_chk       = 1'b0;
    model_regs    = '{default: '0};
    model_mem     = '{default: '0};
    raw_hits      = 0;
    pc            = 0;
    pending       = 1'b0;
    seen_beat     = 1'b0;
    halt_taken    = 1'b0;
    halt_cycles   = 0;
    raw_next      = 1'b0;
    prev_wr       = 1'b0;
    prev_dst      = '0;
    make_program();
    cycle_limit = 8 * prog.size() + 50;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n_i = 1'b1;
    while (halt_cycles < 8) begin
      if (seen_beat && exp_q.size() > 0) begin
        exp_q.delete(0);
      end
      seen_beat = wb_valid_o;
      raw_chk   = raw_next;  // checked at the coming rising edge
      raw_next  = 1'b0;
      if (raw_chk) begin
        raw_hits++;
      end
      if (halt_taken) begin
        instr_valid_i = 1'b1;  // keep knocking, nothing may enter
        instr_i       = ldi_word(reg_idx_t'($urandom_range(7)), 9'($urandom));
      end else if (!pending && $urandom_range(4) == 0) begin
        instr_valid_i = 1'b0;  // idle gap
        instr_i       = word_t'($urandom);
      end else begin
        instr_valid_i = 1'b1;
        instr_i       = prog[pc];
      end
      // ready only changes on rising edges
      accepted = instr_valid_i && instr_ready_o;
      pending  = instr_valid_i && !accepted && !halt_taken;
      if (accepted && halt_taken) begin
        fail_run($sformatf("instruction 0x%h accepted after halt at %0t", instr_i, $time));
      end else if (accepted) begin
        raw_next = prev_wr && reads_reg(instr_i, prev_dst);
        run_model(instr_i);
        halt_taken = (opcode_e'(instr_i[15:12]) == HALT);
        pc++;
      end
      prev_wr  = accepted && writes_reg(instr_i);
      prev_dst = instr_i[11:9];
      exp_avail = (exp_q.size() > 0);
      if (exp_avail) begin
        exp_reg  = exp_q[0][EXP_W-1 -: $bits(reg_idx_t)];
        exp_data = exp_q[0][$bits(word_t)-1:0];
      end
      if (halt_o) begin
        halt_cycles++;
      end
      @(negedge clk);
    end
    if (exp_q.size() != 0) begin
      fail_run($sformatf("halt reached with %0d writebacks missing", exp_q.size()));
    end else if (raw_hits == 0) begin
      fail_run("stimulus never fed a dependent instruction right behind its producer");
    end else begin
      $display("ALL TESTS PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+hw
hw/isa_pkg.sv
hw/pipe_pkg.sv
hw/decode_unit.sv
hw/reg_file.sv
hw/hazard_unit.sv
hw/pipe_id_ex.sv
hw/exec_unit.sv
hw/mem_wb_stage.sv
hw/core_top.sv
tests/core_tb.sv
